//--- dv/umiram_golden.txt
// id port cmd dstaddr srcaddr data flag(0 none,1 full,2 no data) resp_cmd resp_data
// port f marks a barrier, port e ends the list
01 0 08530003 0010 1000 5a 1 08530004 0
02 0 08530001 0010 1000 0 1 08530002 5a
03 0 08530023 0020 1000 1234 1 08530024 0
04 0 08530021 0020 1000 0 1 08530022 1234
05 0 08530043 0030 1000 deadbeef 1 08530044 0
06 0 08530041 0030 1000 0 1 08530042 deadbeef
07 0 08530063 0040 1000 0123456789abcdef 1 08530064 0
08 0 08530061 0040 1000 0 1 08530062 0123456789abcdef
09 0 08530303 0050 1000 a1b2c3d4 1 08530304 0
0a 0 08530301 0050 1000 0 1 08530302 a1b2c3d4
0b 0 08530045 0058 1000 11223344 0 0 0
0c 0 08530041 0058 1000 0 1 08530042 11223344
21 1 12530063 0080 2000 fedcba9876543210 1 12530064 0
22 1 12530061 0080 2000 0 1 12530062 fedcba9876543210
23 1 12530021 0082 2000 0 1 12530022 7654
24 1 12530103 00f0 2000 beef 1 12530104 0
25 1 12530101 00f0 2000 0 1 12530102 beef
51 0 08530003 0060 1000 f0 1 08530004 0
52 0 08530109 0060 1000 85 1 08530002 f0
53 0 08530509 0060 1000 90 1 08530002 75
54 0 08530609 0060 1000 90 1 08530002 75
55 0 08530709 0060 1000 80 1 08530002 90
56 0 08530809 0060 1000 7f 1 08530002 90
57 0 08530209 0060 1000 f3 1 08530002 7f
58 0 08530309 0060 1000 84 1 08530002 73
59 0 08530409 0060 1000 ff 1 08530002 f7
5a 0 08530009 0060 1000 c6 1 08530002 08
5b 0 08530001 0060 1000 0 1 08530002 c6
61 0 08530063 0070 1000 8000000000000010 1 08530064 0
62 0 08530569 0070 1000 ffffffffffffff00 1 08530062 8000000000000010
63 0 08530869 0070 1000 8000000000000001 1 08530062 ffffffffffffff00
64 0 08530169 0070 1000 fffffffffffffffe 1 08530062 8000000000000001
65 0 08530369 0070 1000 8000000000000000 1 08530062 7fffffffffffffff
66 0 08530061 0070 1000 0 1 08530062 ffffffffffffffff
71 1 12530043 00a0 2000 fffffff0 1 12530044 0
72 1 12530149 00a0 2000 80000005 1 12530042 fffffff0
73 1 12530649 00a0 2000 fffffffe 1 12530042 7ffffff5
74 1 12530749 00a0 2000 12345678 1 12530042 fffffffe
75 1 12530449 00a0 2000 f0f0f0f0 1 12530042 fffffffe
76 1 12530041 00a0 2000 0 1 12530042 0f0f0f0e
00 f 0 0 0 0 0 0 0
31 0 08530063 0000 1000 1111111122222222 1 08530064 0
41 1 12530063 0090 2000 3333333344444444 1 12530064 0
32 0 08530023 0008 1000 abcd 1 08530024 0
42 1 12530043 0098 2000 55667788 1 12530044 0
33 0 08530061 0000 1000 0 1 08530062 1111111122222222
43 1 12530061 0090 2000 0 1 12530062 3333333344444444
34 0 08530021 0008 1000 0 1 08530022 abcd
44 1 12530041 0098 2000 0 1 12530042 55667788
35 0 08530043 0044 1000 00000100 1 08530044 0
00 f 0 0 0 0 0 0 0
81 0 08530149 0044 1000 10 2 08530042 0
91 1 12530149 0044 2000 200 2 12530042 0
82 0 08530149 0044 1000 10 2 08530042 0
92 1 12530149 0044 2000 3 2 12530042 0
00 f 0 0 0 0 0 0 0
83 0 08530041 0044 1000 0 1 08530042 00000323
00 e 0 0 0 0 0 0 0

//--- umiram_top.f
src/umi_pkg.sv
src/umiram_cfg_pkg.sv
src/umi_atomic_alu.sv
src/umiram_mem.sv
src/umiram_arb.sv
src/umi_req_port.sv
src/umiram_top.sv
dv/umiram_chk.sv
dv/umiram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f umiram_top.f \
    --top-module umiram_tb -o umiram_sim &&
./obj_dir/umiram_sim | tee /dev/stderr | grep "^PASS: all tests$" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- dv/umiram_tb.sv
`timescale 1ns/1ps

module umiram_tb;
    import umi_pkg::*;
    import umiram_cfg_pkg::*;

    // id port cmd dstaddr srcaddr data flag resp_cmd resp_data
    localparam int rec_words = 9;
    localparam int max_recs  = 96;

    logic      clk;
    logic      rst_n;
    logic      req_valid [2];
    logic      req_ready [2];
    umi_cmd_t  req_cmd [2];
    umi_addr_t req_dstaddr [2];
    umi_addr_t req_srcaddr [2];
    umi_data_t req_data [2];
    logic      resp_valid [2];
    logic      resp_ready [2];
    umi_cmd_t  resp_cmd [2];
    umi_addr_t resp_dstaddr [2];
    umi_addr_t resp_srcaddr [2];
    umi_data_t resp_data [2];

    logic [63:0] gold [rec_words*max_recs];
    int          n_rec;
    int          n_pass;
    int          n_fail;
    int          pend0 [$];
    int          pend1 [$];

    umiram_top dut_i (
        .clk, .rst_n,
        .udev0_req_valid(req_valid[0]), .udev0_req_ready(req_ready[0]),
        .udev0_req_cmd(req_cmd[0]), .udev0_req_dstaddr(req_dstaddr[0]),
        .udev0_req_srcaddr(req_srcaddr[0]), .udev0_req_data(req_data[0]),
        .udev0_resp_valid(resp_valid[0]), .udev0_resp_ready(resp_ready[0]),
        .udev0_resp_cmd(resp_cmd[0]), .udev0_resp_dstaddr(resp_dstaddr[0]),
        .udev0_resp_srcaddr(resp_srcaddr[0]), .udev0_resp_data(resp_data[0]),
        .udev1_req_valid(req_valid[1]), .udev1_req_ready(req_ready[1]),
        .udev1_req_cmd(req_cmd[1]), .udev1_req_dstaddr(req_dstaddr[1]),
        .udev1_req_srcaddr(req_srcaddr[1]), .udev1_req_data(req_data[1]),
        .udev1_resp_valid(resp_valid[1]), .udev1_resp_ready(resp_ready[1]),
        .udev1_resp_cmd(resp_cmd[1]), .udev1_resp_dstaddr(resp_dstaddr[1]),
        .udev1_resp_srcaddr(resp_srcaddr[1]), .udev1_resp_data(resp_data[1])
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [63:0] fld(input int r, input int k);
        return gold[r*rec_words+k];
    endfunction

    function automatic int pending_count(input int p);
        return (p == 0) ? pend0.size() : pend1.size();
    endfunction

    task automatic send_req(input int p, input int r);
        @(negedge clk);
        req_valid[p]   = 1'b1;
        req_cmd[p]     = umi_cmd_t'(fld(r, 2));
        req_dstaddr[p] = umi_addr_t'(fld(r, 3));
        req_srcaddr[p] = umi_addr_t'(fld(r, 4));
        req_data[p]    = fld(r, 5);
        while (!req_ready[p]) @(negedge clk);
        if (fld(r, 6) != 0) begin
            if (p == 0) pend0.push_back(r);
            else pend1.push_back(r);
        end else begin
            $display("test %02h port %0d posted write accepted", fld(r, 0), p);
            n_pass++;
        end
        // accepted on the next rising edge
        @(negedge clk);
        req_valid[p] = 1'b0;
    endtask

    task automatic drive_segment(input int p, input int first, input int last);
        for (int r = first; r < last; r++) begin
            if (fld(r, 1) == 64'(p)) send_req(p, r);
        end
    endtask

    task automatic check_resp(input int p);
        int   r;
        int   stall;
        logic ok;
        forever begin
            @(negedge clk);
            resp_ready[p] = 1'b0;
            if (resp_valid[p]) begin
                stall = $urandom % 4;
                repeat (stall) @(negedge clk);
                resp_ready[p] = 1'b1;
                if (pending_count(p) == 0) begin
                    $display("ERROR port %0d: response with no request outstanding", p);
                    n_fail++;
                end else begin
                    r  = (p == 0) ? pend0.pop_front() : pend1.pop_front();
                    ok = 1'b1;
                    if (resp_cmd[p] !== umi_cmd_t'(fld(r, 7))) begin
                        $display("ERROR test %02h resp_cmd: expected %h actual %h",
                                 fld(r, 0), umi_cmd_t'(fld(r, 7)), resp_cmd[p]);
                        ok = 1'b0;
                    end
                    if (resp_dstaddr[p] !== umi_addr_t'(fld(r, 4))) begin
                        $display("ERROR test %02h resp_dstaddr: expected %h actual %h",
                                 fld(r, 0), umi_addr_t'(fld(r, 4)), resp_dstaddr[p]);
                        ok = 1'b0;
                    end
                    if (resp_srcaddr[p] !== umi_addr_t'(fld(r, 3))) begin
                        $display("ERROR test %02h resp_srcaddr: expected %h actual %h",
                                 fld(r, 0), umi_addr_t'(fld(r, 3)), resp_srcaddr[p]);
                        ok = 1'b0;
                    end
                    // flag 2 means the old value depends on arbitration
                    if (fld(r, 6) == 1 && resp_data[p] !== fld(r, 8)) begin
                        $display("ERROR test %02h resp_data: expected %h actual %h",
                                 fld(r, 0), fld(r, 8), resp_data[p]);
                        ok = 1'b0;
                    end
                    if (ok) n_pass++;
                    else n_fail++;
                    $display("test %02h port %0d %s", fld(r, 0), p, ok ? "ok" : "failed");
                end
            end
        end
    endtask

    initial begin
        int         seg_start;
        logic [3:0] idle_bits;
        for (int p = 0; p < 2; p++) begin
            req_valid[p]   = 1'b0;
            req_cmd[p]     = '0;
            req_dstaddr[p] = '0;
            req_srcaddr[p] = '0;
            req_data[p]    = '0;
            resp_ready[p]  = 1'b0;
        end
        rst_n  = 1'b0;
        n_pass = 0;
        n_fail = 0;
        void'($urandom(32'h5a5ae6a1));
        $readmemh("dv/umiram_golden.txt", gold);
        n_rec = 0;
        while (n_rec < max_recs && fld(n_rec, 1) != 64'he) n_rec++;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // resp_valid 1, resp_valid 0, req_ready 1, req_ready 0
        idle_bits = {resp_valid[1], resp_valid[0], req_ready[1], req_ready[0]};
        if (idle_bits !== 4'b0011) begin
            $display("ERROR test reset: expected %b actual %b", 4'b0011, idle_bits);
            n_fail++;
        end else begin
            $display("test reset ok");
            n_pass++;
        end

        fork
            check_resp(0);
            check_resp(1);
        join_none

        // records up to each barrier run on both ports at once
        seg_start = 0;
        for (int r = 0; r <= n_rec; r++) begin
            if (r == n_rec || fld(r, 1) == 64'hf) begin
                fork
                    drive_segment(0, seg_start, r);
                    drive_segment(1, seg_start, r);
                join
                while (pend0.size() != 0 || pend1.size() != 0) @(negedge clk);
                seg_start = r + 1;
            end
        end
        repeat (8) @(negedge clk);

        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (n_rec * 40 + 200) @(posedge clk);
        $display("watchdog expired, a response never arrived");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- dv/umiram_chk.sv
`timescale 1ns/1ps

module umiram_chk (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      resp_valid,
    input logic                      resp_ready,
    input umi_pkg::umi_cmd_t         resp_cmd,
    input umiram_cfg_pkg::umi_addr_t resp_dstaddr,
    input umiram_cfg_pkg::umi_addr_t resp_srcaddr,
    input umiram_cfg_pkg::umi_data_t resp_data,
    input logic [1:0]                req,
    input logic [1:0]                gnt
);

    // response held while the host stalls
    resp_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd)
        && $stable(resp_dstaddr) && $stable(resp_srcaddr) && $stable(resp_data))
        else $error("response changed while stalled");

    gnt_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(gnt[0] && gnt[1]))
        else $error("both grants high");

    gnt0_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        gnt[0] |-> req[0])
        else $error("grant 0 without request");

    gnt1_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        gnt[1] |-> req[1])
        else $error("grant 1 without request");

endmodule

bind umi_req_port umiram_chk u_chk (
    .clk, .rst_n, .resp_valid, .resp_ready, .resp_cmd, .resp_dstaddr, .resp_srcaddr,
    .resp_data, .req({1'b0, mem_req}), .gnt({1'b0, mem_gnt})
);

bind umiram_arb umiram_chk u_chk (
    .clk, .rst_n, .resp_valid(1'b0), .resp_ready(1'b1), .resp_cmd('0),
    .resp_dstaddr('0), .resp_srcaddr('0), .resp_data('0),
    .req({p1_req, p0_req}), .gnt({p1_gnt, p0_gnt})
);

//--- src/umiram_top.sv
`timescale 1ns/1ps

module umiram_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      udev0_req_valid,
    output logic                      udev0_req_ready,
    input  umi_pkg::umi_cmd_t         udev0_req_cmd,
    input  umiram_cfg_pkg::umi_addr_t udev0_req_dstaddr,
    input  umiram_cfg_pkg::umi_addr_t udev0_req_srcaddr,
    input  umiram_cfg_pkg::umi_data_t udev0_req_data,
    output logic                      udev0_resp_valid,
    input  logic                      udev0_resp_ready,
    output umi_pkg::umi_cmd_t         udev0_resp_cmd,
    output umiram_cfg_pkg::umi_addr_t udev0_resp_dstaddr,
    output umiram_cfg_pkg::umi_addr_t udev0_resp_srcaddr,
    output umiram_cfg_pkg::umi_data_t udev0_resp_data,
    input  logic                      udev1_req_valid,
    output logic                      udev1_req_ready,
    input  umi_pkg::umi_cmd_t         udev1_req_cmd,
    input  umiram_cfg_pkg::umi_addr_t udev1_req_dstaddr,
    input  umiram_cfg_pkg::umi_addr_t udev1_req_srcaddr,
    input  umiram_cfg_pkg::umi_data_t udev1_req_data,
    output logic                      udev1_resp_valid,
    input  logic                      udev1_resp_ready,
    output umi_pkg::umi_cmd_t         udev1_resp_cmd,
    output umiram_cfg_pkg::umi_addr_t udev1_resp_dstaddr,
    output umiram_cfg_pkg::umi_addr_t udev1_resp_srcaddr,
    output umiram_cfg_pkg::umi_data_t udev1_resp_data
);
    import umi_pkg::*;
    import umiram_cfg_pkg::*;

    // port side of the arbiter
    logic       p0_req, p0_write, p0_atomic, p0_gnt, p0_rvalid;
    logic       p1_req, p1_write, p1_atomic, p1_gnt, p1_rvalid;
    umi_atype_t p0_atype, p1_atype;
    mem_addr_t  p0_addr, p1_addr;
    umi_size_t  p0_size, p1_size;
    nbytes_t    p0_nbytes, p1_nbytes;
    umi_data_t  p0_wdata, p1_wdata, p0_rdata, p1_rdata;

    // RAM side
    logic       mem_en, mem_write, mem_atomic;
    umi_atype_t mem_atype;
    mem_addr_t  mem_addr;
    umi_size_t  mem_size;
    nbytes_t    mem_nbytes;
    umi_data_t  mem_wdata, rd_data;

    umi_req_port u_port0 (
        .clk, .rst_n,
        .req_valid    (udev0_req_valid),
        .req_ready    (udev0_req_ready),
        .req_cmd      (udev0_req_cmd),
        .req_dstaddr  (udev0_req_dstaddr),
        .req_srcaddr  (udev0_req_srcaddr),
        .req_data     (udev0_req_data),
        .resp_valid   (udev0_resp_valid),
        .resp_ready   (udev0_resp_ready),
        .resp_cmd     (udev0_resp_cmd),
        .resp_dstaddr (udev0_resp_dstaddr),
        .resp_srcaddr (udev0_resp_srcaddr),
        .resp_data    (udev0_resp_data),
        .mem_req      (p0_req),
        .mem_write    (p0_write),
        .mem_atomic   (p0_atomic),
        .mem_atype    (p0_atype),
        .mem_addr     (p0_addr),
        .mem_size     (p0_size),
        .mem_nbytes   (p0_nbytes),
        .mem_wdata    (p0_wdata),
        .mem_gnt      (p0_gnt),
        .mem_rvalid   (p0_rvalid),
        .mem_rdata    (p0_rdata)
    );

    umi_req_port u_port1 (
        .clk, .rst_n,
        .req_valid    (udev1_req_valid),
        .req_ready    (udev1_req_ready),
        .req_cmd      (udev1_req_cmd),
        .req_dstaddr  (udev1_req_dstaddr),
        .req_srcaddr  (udev1_req_srcaddr),
        .req_data     (udev1_req_data),
        .resp_valid   (udev1_resp_valid),
        .resp_ready   (udev1_resp_ready),
        .resp_cmd     (udev1_resp_cmd),
        .resp_dstaddr (udev1_resp_dstaddr),
        .resp_srcaddr (udev1_resp_srcaddr),
        .resp_data    (udev1_resp_data),
        .mem_req      (p1_req),
        .mem_write    (p1_write),
        .mem_atomic   (p1_atomic),
        .mem_atype    (p1_atype),
        .mem_addr     (p1_addr),
        .mem_size     (p1_size),
        .mem_nbytes   (p1_nbytes),
        .mem_wdata    (p1_wdata),
        .mem_gnt      (p1_gnt),
        .mem_rvalid   (p1_rvalid),
        .mem_rdata    (p1_rdata)
    );

    umiram_arb u_arb (
        .clk, .rst_n,
        .p0_req, .p0_write, .p0_atomic, .p0_atype, .p0_addr, .p0_size,
        .p0_nbytes, .p0_wdata, .p0_gnt, .p0_rvalid, .p0_rdata,
        .p1_req, .p1_write, .p1_atomic, .p1_atype, .p1_addr, .p1_size,
        .p1_nbytes, .p1_wdata, .p1_gnt, .p1_rvalid, .p1_rdata,
        .mem_en, .mem_write, .mem_atomic, .mem_atype, .mem_addr, .mem_size,
        .mem_nbytes, .mem_wdata, .rd_data
    );

    umiram_mem u_mem (
        .clk, .rst_n,
        .mem_en, .mem_write, .mem_atomic, .mem_atype, .mem_addr, .mem_size,
        .mem_nbytes, .mem_wdata, .rd_data
    );

endmodule

//--- src/umi_req_port.sv
`timescale 1ns/1ps

module umi_req_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  umi_pkg::umi_cmd_t        req_cmd,
    input  umiram_cfg_pkg::umi_addr_t req_dstaddr,
    input  umiram_cfg_pkg::umi_addr_t req_srcaddr,
    input  umiram_cfg_pkg::umi_data_t req_data,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output umi_pkg::umi_cmd_t        resp_cmd,
    output umiram_cfg_pkg::umi_addr_t resp_dstaddr,
    output umiram_cfg_pkg::umi_addr_t resp_srcaddr,
    output umiram_cfg_pkg::umi_data_t resp_data,
    output logic                     mem_req,
    output logic                     mem_write,
    output logic                     mem_atomic,
    output umi_pkg::umi_atype_t      mem_atype,
    output umiram_cfg_pkg::mem_addr_t mem_addr,
    output umi_pkg::umi_size_t       mem_size,
    output umiram_cfg_pkg::nbytes_t  mem_nbytes,
    output umiram_cfg_pkg::umi_data_t mem_wdata,
    input  logic                     mem_gnt,
    input  logic                     mem_rvalid,
    input  umiram_cfg_pkg::umi_data_t mem_rdata
);
    import umi_pkg::*;
    import umiram_cfg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_grant,
        st_wait_data,
        st_respond
    } state_t;

    state_t      state;
    umi_cmd_t    cmd_q;
    umi_addr_t   dstaddr_q;
    umi_addr_t   srcaddr_q;
    umi_data_t   data_q;
    umi_opcode_t opcode;
    logic        is_read;
    logic        is_write;
    logic        is_posted;
    logic        is_atomic;
    nbytes_t     len_eff;

    assign opcode    = cmd_q[umi_opcode_lsb +: umi_opcode_w];
    assign is_read   = opcode == umi_req_read;
    assign is_write  = opcode == umi_req_write;
    assign is_posted = opcode == umi_req_posted;
    assign is_atomic = opcode == umi_req_atomic;

    // atomics always move one word
    assign len_eff    = is_atomic ? '0 : nbytes_t'(cmd_q[umi_len_lsb +: umi_len_w]);
    assign mem_size   = cmd_q[umi_size_lsb +: umi_size_w];
    assign mem_nbytes = (len_eff + nbytes_t'(1)) << mem_size;

    assign req_ready  = state == st_idle;
    assign mem_req    = state == st_wait_grant;
    assign mem_write  = is_write | is_posted;
    assign mem_atomic = is_atomic;
    assign mem_atype  = cmd_q[umi_atype_lsb +: umi_atype_w];
    assign mem_addr   = dstaddr_q[mem_addr_w-1:0];
    assign mem_wdata  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_wait_grant;
                    end
                end
                st_wait_grant: begin
                    // posted writes are done once granted
                    if (mem_gnt) begin
                        state <= is_posted ? st_idle : st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (mem_rvalid) begin
                        state <= st_respond;
                    end
                end
                default: begin
                    if (resp_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cmd_q     <= req_cmd;
            dstaddr_q <= req_dstaddr;
            srcaddr_q <= req_srcaddr;
            data_q    <= req_data;
        end
        if (state == st_wait_data && mem_rvalid) begin
            resp_data <= (is_read || is_atomic) ? mem_rdata : '0;
        end
    end

    assign resp_valid   = state == st_respond;
    assign resp_dstaddr = srcaddr_q;
    assign resp_srcaddr = dstaddr_q;

    always_comb begin
        resp_cmd = '0;
        resp_cmd[umi_opcode_lsb +: umi_opcode_w] = is_write ? umi_resp_write : umi_resp_read;
        resp_cmd[umi_size_lsb +: umi_size_w]     = mem_size;
        resp_cmd[umi_len_lsb +: umi_len_w]       = is_atomic ? '0 : cmd_q[umi_len_lsb +: umi_len_w];
        resp_cmd[umi_qos_lsb +: umi_qos_w]       = cmd_q[umi_qos_lsb +: umi_qos_w];
        resp_cmd[umi_prot_lsb +: umi_prot_w]     = cmd_q[umi_prot_lsb +: umi_prot_w];
        resp_cmd[umi_eom_lsb]                    = cmd_q[umi_eom_lsb];
        resp_cmd[umi_eof_lsb]                    = cmd_q[umi_eof_lsb];
        resp_cmd[umi_ex_lsb]                     = cmd_q[umi_ex_lsb];
        resp_cmd[umi_user_lsb +: umi_user_w]     = cmd_q[umi_user_lsb +: umi_user_w];
        resp_cmd[umi_hostid_lsb +: umi_hostid_w] = cmd_q[umi_hostid_lsb +: umi_hostid_w];
    end

endmodule

//--- src/umiram_arb.sv
`timescale 1ns/1ps

module umiram_arb (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      p0_req,
    input  logic                      p0_write,
    input  logic                      p0_atomic,
    input  umi_pkg::umi_atype_t       p0_atype,
    input  umiram_cfg_pkg::mem_addr_t p0_addr,
    input  umi_pkg::umi_size_t        p0_size,
    input  umiram_cfg_pkg::nbytes_t   p0_nbytes,
    input  umiram_cfg_pkg::umi_data_t p0_wdata,
    output logic                      p0_gnt,
    output logic                      p0_rvalid,
    output umiram_cfg_pkg::umi_data_t p0_rdata,
    input  logic                      p1_req,
    input  logic                      p1_write,
    input  logic                      p1_atomic,
    input  umi_pkg::umi_atype_t       p1_atype,
    input  umiram_cfg_pkg::mem_addr_t p1_addr,
    input  umi_pkg::umi_size_t        p1_size,
    input  umiram_cfg_pkg::nbytes_t   p1_nbytes,
    input  umiram_cfg_pkg::umi_data_t p1_wdata,
    output logic                      p1_gnt,
    output logic                      p1_rvalid,
    output umiram_cfg_pkg::umi_data_t p1_rdata,
    output logic                      mem_en,
    output logic                      mem_write,
    output logic                      mem_atomic,
    output umi_pkg::umi_atype_t       mem_atype,
    output umiram_cfg_pkg::mem_addr_t mem_addr,
    output umi_pkg::umi_size_t        mem_size,
    output umiram_cfg_pkg::nbytes_t   mem_nbytes,
    output umiram_cfg_pkg::umi_data_t mem_wdata,
    input  umiram_cfg_pkg::umi_data_t rd_data
);
    import umiram_cfg_pkg::*;

    logic [n_ports-1:0] req;
    logic [n_ports-1:0] gnt;
    // high when port 1 won the last grant
    logic               last_gnt;
    logic               rd_pending;
    logic               rd_owner;

    assign req = {p1_req, p0_req};

    // on a tie the port not granted last wins
    assign gnt[0] = req[0] & (~req[1] | last_gnt);
    assign gnt[1] = req[1] & (~req[0] | ~last_gnt);

    assign p0_gnt = gnt[0];
    assign p1_gnt = gnt[1];
    assign mem_en = |gnt;

    assign mem_write  = gnt[1] ? p1_write  : p0_write;
    assign mem_atomic = gnt[1] ? p1_atomic : p0_atomic;
    assign mem_atype  = gnt[1] ? p1_atype  : p0_atype;
    assign mem_addr   = gnt[1] ? p1_addr   : p0_addr;
    assign mem_size   = gnt[1] ? p1_size   : p0_size;
    assign mem_nbytes = gnt[1] ? p1_nbytes : p0_nbytes;
    assign mem_wdata  = gnt[1] ? p1_wdata  : p0_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_gnt   <= 1'b0;
            rd_pending <= 1'b0;
            rd_owner   <= 1'b0;
        end else begin
            rd_pending <= mem_en;
            if (mem_en) begin
                last_gnt <= gnt[1];
                rd_owner <= gnt[1];
            end
        end
    end

    // read data lands one cycle after the grant
    assign p0_rvalid = rd_pending & ~rd_owner;
    assign p1_rvalid = rd_pending & rd_owner;
    assign p0_rdata  = rd_data;
    assign p1_rdata  = rd_data;

endmodule

//--- src/umiram_mem.sv
`timescale 1ns/1ps

module umiram_mem (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_en,
    input  logic                      mem_write,
    input  logic                      mem_atomic,
    input  umi_pkg::umi_atype_t       mem_atype,
    input  umiram_cfg_pkg::mem_addr_t mem_addr,
    input  umi_pkg::umi_size_t        mem_size,
    input  umiram_cfg_pkg::nbytes_t   mem_nbytes,
    input  umiram_cfg_pkg::umi_data_t mem_wdata,
    output umiram_cfg_pkg::umi_data_t rd_data
);
    import umiram_cfg_pkg::*;

    logic [7:0]            mem [mem_depth];
    mem_addr_t             byte_addr [data_bytes];
    logic [data_bytes-1:0] byte_en;
    umi_data_t             old_data;
    umi_data_t             alu_y;
    umi_data_t             new_data;

    // byte lanes, address wraps at the top of the RAM
    always_comb begin
        for (int i = 0; i < data_bytes; i++) begin
            byte_addr[i]       = mem_addr + mem_addr_t'(i);
            byte_en[i]         = i < int'(mem_nbytes);
            old_data[i*8 +: 8] = byte_en[i] ? mem[byte_addr[i]] : 8'h00;
        end
    end

    umi_atomic_alu u_alu (
        .a     (old_data),
        .b     (mem_wdata),
        .size  (mem_size),
        .atype (mem_atype),
        .y     (alu_y)
    );

    assign new_data = mem_atomic ? alu_y : mem_wdata;

    always_ff @(posedge clk) begin
        if (mem_en && (mem_write || mem_atomic)) begin
            for (int i = 0; i < data_bytes; i++) begin
                if (byte_en[i]) begin
                    mem[byte_addr[i]] <= new_data[i*8 +: 8];
                end
            end
        end
    end

    // old contents, also for atomics
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (mem_en) begin
            rd_data <= old_data;
        end
    end

endmodule

//--- src/umi_atomic_alu.sv
`timescale 1ns/1ps

module umi_atomic_alu (
    input  umiram_cfg_pkg::umi_data_t a,
    input  umiram_cfg_pkg::umi_data_t b,
    input  umi_pkg::umi_size_t        size,
    input  umi_pkg::umi_atype_t       atype,
    output umiram_cfg_pkg::umi_data_t y
);
    import umi_pkg::*;
    import umiram_cfg_pkg::*;

    logic [6:0]                    nshift;
    logic                          sext;
    umi_data_t                     au;
    umi_data_t                     bu;
    logic signed [umi_data_w-1:0]  as_ext;
    logic signed [umi_data_w-1:0]  bs_ext;
    umi_data_t                     ax;
    umi_data_t                     bx;

    // operand width is 8 << size bits, full word from size 3 up
    always_comb begin
        if (size >= 3'd3) begin
            nshift = '0;
        end else begin
            nshift = 7'(umi_data_w) - (7'd8 << size);
        end
    end

    assign sext = (atype == umi_atomic_add) || (atype == umi_atomic_max)
                || (atype == umi_atomic_min);

    assign au     = (a << nshift) >> nshift;
    assign bu     = (b << nshift) >> nshift;
    assign as_ext = $signed(a << nshift) >>> nshift;
    assign bs_ext = $signed(b << nshift) >>> nshift;
    assign ax     = sext ? umi_data_t'(as_ext) : au;
    assign bx     = sext ? umi_data_t'(bs_ext) : bu;

    always_comb begin
        case (atype)
            umi_atomic_swap: y = bx;
            umi_atomic_add:  y = ax + bx;
            umi_atomic_and:  y = ax & bx;
            umi_atomic_or:   y = ax | bx;
            umi_atomic_xor:  y = ax ^ bx;
            umi_atomic_max:  y = ($signed(ax) >= $signed(bx)) ? ax : bx;
            umi_atomic_min:  y = ($signed(ax) <= $signed(bx)) ? ax : bx;
            umi_atomic_maxu: y = (au >= bu) ? au : bu;
            umi_atomic_minu: y = (au <= bu) ? au : bu;
            default:         y = '0;
        endcase
    end

endmodule

//--- src/umiram_cfg_pkg.sv
package umiram_cfg_pkg;

    localparam int umi_addr_w = 16;
    localparam int umi_data_w = 64;
    localparam int mem_addr_w = 8;

    // bytes in one data word and in the whole RAM
    localparam int data_bytes = umi_data_w / 8;
    localparam int mem_depth  = 2 ** mem_addr_w;

    localparam int n_ports = 2;

    typedef logic [umi_addr_w-1:0] umi_addr_t;
    typedef logic [umi_data_w-1:0] umi_data_t;
    typedef logic [mem_addr_w-1:0] mem_addr_t;
    // byte count of one transfer, 1 to 8
    typedef logic [3:0]            nbytes_t;

endpackage

//--- src/umi_pkg.sv
package umi_pkg;

    typedef logic [31:0] umi_cmd_t;
    typedef logic [4:0]  umi_opcode_t;
    typedef logic [2:0]  umi_size_t;
    typedef logic [7:0]  umi_atype_t;

    // command word field positions
    localparam int umi_opcode_lsb = 0;
    localparam int umi_opcode_w   = 5;
    localparam int umi_size_lsb   = 5;
    localparam int umi_size_w     = 3;
    // len and atype share the same bits
    localparam int umi_len_lsb    = 8;
    localparam int umi_len_w      = 8;
    localparam int umi_atype_lsb  = 8;
    localparam int umi_atype_w    = 8;
    localparam int umi_qos_lsb    = 16;
    localparam int umi_qos_w      = 4;
    localparam int umi_prot_lsb   = 20;
    localparam int umi_prot_w     = 2;
    localparam int umi_eom_lsb    = 22;
    localparam int umi_eof_lsb    = 23;
    localparam int umi_ex_lsb     = 24;
    localparam int umi_user_lsb   = 25;
    localparam int umi_user_w     = 2;
    localparam int umi_hostid_lsb = 27;
    localparam int umi_hostid_w   = 5;

    localparam umi_opcode_t umi_req_read   = 5'd1;
    localparam umi_opcode_t umi_resp_read  = 5'd2;
    localparam umi_opcode_t umi_req_write  = 5'd3;
    localparam umi_opcode_t umi_resp_write = 5'd4;
    localparam umi_opcode_t umi_req_posted = 5'd5;
    localparam umi_opcode_t umi_req_atomic = 5'd9;

    localparam umi_atype_t umi_atomic_swap = 8'd0;
    localparam umi_atype_t umi_atomic_add  = 8'd1;
    localparam umi_atype_t umi_atomic_and  = 8'd2;
    localparam umi_atype_t umi_atomic_or   = 8'd3;
    localparam umi_atype_t umi_atomic_xor  = 8'd4;
    localparam umi_atype_t umi_atomic_max  = 8'd5;
    localparam umi_atype_t umi_atomic_min  = 8'd6;
    localparam umi_atype_t umi_atomic_maxu = 8'd7;
    localparam umi_atype_t umi_atomic_minu = 8'd8;

endpackage
